/* list.f */
+incdir+include
rtl/bus_pkg.sv
rtl/map_pkg.sv
rtl/dec_if.sv
rtl/bus_decoder.sv
rtl/hello_rom.sv
rtl/scratch_ram.sv
rtl/console_port.sv
rtl/hello_bus_top.sv
tests/hello_bus_assert.sv
tests/tb_hello_bus.sv

/* run.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and check the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_hello_bus \
	-Mdir obj_dir -o sim_hello_bus

./obj_dir/sim_hello_bus | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
	exit 0
else
	exit 1
fi

/* tests/tb_hello_bus.sv */
// ----------------------------
// Table-driven testbench for
// the memory and I/O subsystem.
// ----------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_hello_bus
	import bus_pkg::*, map_pkg::*;
;
	localparam int RAM_W   = 10;
	localparam int TIMEOUT = 20;	// Cycles per wait.
	localparam bus_data_t ROM_IMAGE [0:ROM_SIZE-1] = '{
		8'hF3, 8'hC3, 8'h08, 8'h00, 8'h00, 8'hC3, 8'h2E, 8'h00,
		8'h31, 8'h00, 8'h40, 8'hCD, 8'h2B, 8'h00, 8'hE6, 8'h01,
		8'h28, 8'hF9, 8'h11, 8'h1B, 8'h00, 8'hCD, 8'h2E, 8'h00,
		8'hC3, 8'h0B, 8'h00, 8'h48, 8'h65, 8'h6C, 8'h6C, 8'h6F,
		8'h2C, 8'h20, 8'h77, 8'h6F, 8'h72, 8'h6C, 8'h64, 8'h21,
		8'h0D, 8'h0A, 8'h00, 8'hDB, 8'h10, 8'hC9, 8'hF5, 8'h1A,
		8'h13, 8'hB7, 8'h28, 8'h04, 8'hD3, 8'h10, 8'h18, 8'hF7,
		8'hF1, 8'hC9
	};

	typedef enum logic [1:0] {k_read, k_write, k_io_read, k_io_write} kind_t;
	typedef struct {
		kind_t     kind;
		bus_addr_t addr;
		bus_data_t data;
		bus_data_t exp_data;
		logic      resp;	// Read data expected.
		logic      tx_rdy;
	} step_t;

	logic      clk;
	logic      reset_n;
	bus_addr_t bus_address;
	logic      bus_memreq;
	logic      bus_valid;
	logic      bus_write;
	bus_data_t bus_wdata;
	logic      bus_ready;
	bus_data_t bus_rdata;
	logic      bus_rdata_en;
	logic      tx_ready;
	bus_data_t tx_data;
	logic      tx_strobe;
	step_t     steps [$];
	logic [31:0] lcg_state;
	logic      run_ok = 1'b0;
	logic      fail_printed = 1'b0;

	hello_bus_top #(.RAM_ADDR_W(RAM_W)) UUT (.*);

	bind hello_bus_top hello_bus_assert u_assert (
		.clk, .reset_n, .bus_rdata, .bus_rdata_en, .tx_ready, .tx_strobe
	);

	always #20 clk = ~clk;

	function automatic bus_data_t lcg_byte();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:24];
	endfunction

	task automatic abort_run();
		$display("SOME TESTS FAILED");
		fail_printed = 1'b1;
		$fatal(1, "Stopping at first error.");
	endtask

	task automatic check_data(input string name, input bus_data_t got, input bus_data_t exp);
		if (got !== exp) begin
			$display("ERROR %s got 0x%02h expected 0x%02h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERROR %s got 0x%0h expected 0x%0h", name, got, exp);
			abort_run();
		end
	endtask

	task automatic add_step(input kind_t k, input bus_addr_t a, input bus_data_t d,
			input bus_data_t e, input logic r, input logic t);
		step_t s;
		s.kind     = k;
		s.addr     = a;
		s.data     = d;
		s.exp_data = e;
		s.resp     = r;
		s.tx_rdy   = t;
		steps.push_back(s);
	endtask

	task automatic build_steps();
		bus_addr_t ram_addr [4];
		bus_data_t ram_data [4];
		bus_addr_t io_addr;
		string     msg;
		io_addr = {8'h00, CONSOLE_PORT};
		msg = "Hello, world!";
		ram_addr[0] = 16'h3FFF;
		ram_addr[1] = RAM_END - bus_addr_t'(1 << RAM_W);
		ram_addr[2] = ram_addr[1] + 16'h0155;
		ram_addr[3] = ram_addr[1] + 16'h0280;
		for (int i = 0; i < ROM_SIZE; i++)
			add_step(k_read, bus_addr_t'(i), 8'h00, ROM_IMAGE[i], 1'b1, 1'b1);
		add_step(k_read, bus_addr_t'(ROM_SIZE), 8'h00, 8'h00, 1'b1, 1'b1);
		add_step(k_read, 16'h1FFF, 8'h00, 8'h00, 1'b1, 1'b1);
		add_step(k_write, 16'h0005, 8'hAA, 8'h00, 1'b0, 1'b1);
		add_step(k_read, 16'h0005, 8'h00, ROM_IMAGE[5], 1'b1, 1'b1);
		for (int i = 0; i < 4; i++) begin
			ram_data[i] = lcg_byte();
			add_step(k_write, ram_addr[i], ram_data[i], 8'h00, 1'b0, 1'b1);
		end
		for (int i = 0; i < 4; i++)
			add_step(k_read, ram_addr[i], 8'h00, ram_data[i], 1'b1, 1'b1);
		add_step(k_read, 16'h2000, 8'h00, 8'h00, 1'b0, 1'b1);	// Unmapped.
		add_step(k_read, 16'h8000, 8'h00, 8'h00, 1'b0, 1'b1);
		for (int j = 0; j < msg.len(); j++)
			add_step(k_io_write, io_addr, bus_data_t'(msg[j]), bus_data_t'(msg[j]), 1'b0, 1'b1);
		add_step(k_io_read, io_addr, 8'h00, 8'h00, 1'b1, 1'b0);
		add_step(k_io_write, io_addr, 8'h58, 8'h58, 1'b0, 1'b0);	// Held by back-pressure.
		add_step(k_io_read, io_addr, 8'h00, 8'h01, 1'b1, 1'b1);
		add_step(k_io_read, 16'h0011, 8'h00, 8'h00, 1'b0, 1'b1);
	endtask

	task automatic issue(input logic memreq, input logic write, input bus_addr_t addr,
			input bus_data_t data);
		int n;
		n = 0;
		while (!bus_ready) begin
			@(posedge clk);
			#2;
			n++;
			if (n > TIMEOUT) begin
				$display("Timeout waiting for bus_ready at address 0x%04h", addr);
				abort_run();
			end
		end
		bus_address = addr;
		bus_memreq  = memreq;
		bus_write   = write;
		bus_wdata   = data;
		bus_valid   = 1'b1;
		@(posedge clk);	// Accept edge.
		#2;
		bus_valid = 1'b0;
	endtask

	task automatic wait_rdata(input bus_addr_t addr);
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (n > TIMEOUT) begin
				$display("Timeout waiting for read data from address 0x%04h", addr);
				abort_run();
			end
		end while (!bus_rdata_en);
		if (n != 2) begin
			$display("Read data from 0x%04h came on edge %0d counted from accept, not 2",
				addr, n);
			abort_run();
		end
	endtask

	task automatic expect_silence(input bus_addr_t addr);
		repeat (TIMEOUT) begin
			@(negedge clk);
			if (bus_rdata_en) begin
				$display("Unexpected read data for address 0x%04h", addr);
				abort_run();
			end
		end
	endtask

	task automatic wait_strobe();
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (n > TIMEOUT) begin
				$display("Timeout waiting for tx_strobe from the console");
				abort_run();
			end
		end while (!tx_strobe);
	endtask

	task automatic run_step(input step_t s);
		tx_ready = s.tx_rdy;
		case (s.kind)
			k_read, k_io_read: begin
				issue(s.kind == k_read, 1'b0, s.addr, 8'h00);
				if (!s.resp)
					expect_silence(s.addr);
				else begin
					wait_rdata(s.addr);
					if (s.kind == k_read)
						check_data("bus_rdata", bus_rdata, s.exp_data);
					else
						check_bit("status bit 0", bus_rdata[0], s.exp_data[0]);
				end
			end
			k_write: issue(1'b1, 1'b1, s.addr, s.data);
			k_io_write: begin
				issue(1'b0, 1'b1, s.addr, s.data);
				if (!s.tx_rdy) begin
					repeat (6) begin
						@(negedge clk);
						check_bit("bus_ready", bus_ready, 1'b0);
						check_bit("tx_strobe", tx_strobe, 1'b0);
					end
					@(posedge clk);
					#2;
					tx_ready = 1'b1;
				end
				wait_strobe();
				check_data("tx_data", tx_data, s.exp_data);
				@(negedge clk);
				check_bit("bus_ready", bus_ready, 1'b1);
			end
		endcase
		@(posedge clk);
		#2;
	endtask

	initial begin
		clk         = 1'b0;
		reset_n     = 1'b0;
		bus_address = '0;
		bus_memreq  = 1'b0;
		bus_valid   = 1'b0;
		bus_write   = 1'b0;
		bus_wdata   = '0;
		tx_ready    = 1'b1;
		lcg_state   = 32'hcb22_7f40;
		build_steps();
		repeat (8) @(posedge clk);
		#2;
		reset_n = 1'b1;
		@(negedge clk);
		check_bit("bus_ready", bus_ready, 1'b1);
		check_bit("bus_rdata_en", bus_rdata_en, 1'b0);
		check_bit("tx_strobe", tx_strobe, 1'b0);
		@(posedge clk);
		#2;
		foreach (steps[i])
			run_step(steps[i]);
		run_ok = 1'b1;
		$display("ALL TESTS PASSED");
		$finish;
	end

	// Covers a run stopped by an assertion.
	final begin
		if (!run_ok && !fail_printed)
			$display("SOME TESTS FAILED");
	end

endmodule

`default_nettype wire

/* tests/hello_bus_assert.sv */
// ----------------------------
// Bus protocol assertions for
// the subsystem top level.
// ----------------------------
`timescale 1ns/1ps
`default_nettype none

module hello_bus_assert
	import bus_pkg::*;
(
	input logic      clk,
	input logic      reset_n,
	input bus_data_t bus_rdata,
	input logic      bus_rdata_en,
	input logic      tx_ready,
	input logic      tx_strobe
);
	a_rdata_en_single: assert property (@(posedge clk) disable iff (!reset_n)
		bus_rdata_en |=> !bus_rdata_en)
		else $error("bus_rdata_en high for two cycles in a row");

	a_strobe_when_ready: assert property (@(posedge clk) disable iff (!reset_n)
		tx_strobe |-> tx_ready)
		else $error("tx_strobe seen while tx_ready is low");

	// Idle targets must leave the OR merge clean.
	a_rdata_quiet: assert property (@(posedge clk) disable iff (!reset_n)
		!bus_rdata_en |-> (bus_rdata == '0))
		else $error("bus_rdata not zero while bus_rdata_en is low");

endmodule

`default_nettype wire

/* rtl/hello_bus_top.sv */
// ----------------------------
// Memory and I/O subsystem top
// with read-data OR merge.
// ----------------------------
`timescale 1ns/1ps
`default_nettype none

module hello_bus_top
	import bus_pkg::*;
#(
	parameter int RAM_ADDR_W = 10
) (
	input  logic      clk,
	input  logic      reset_n,
	input  bus_addr_t bus_address,
	input  logic      bus_memreq,
	input  logic      bus_valid,
	input  logic      bus_write,
	input  bus_data_t bus_wdata,
	output logic      bus_ready,
	output bus_data_t bus_rdata,
	output logic      bus_rdata_en,
	input  logic      tx_ready,
	output bus_data_t tx_data,
	output logic      tx_strobe
);
	bus_data_t rom_rdata, ram_rdata, io_rdata;
	logic      rom_en, ram_en, io_en;
	logic      port_busy;

	dec_if dec ();

	bus_decoder #(.RAM_ADDR_W(RAM_ADDR_W)) u_decoder (
		.clk, .reset_n, .bus_address, .bus_memreq, .bus_valid, .bus_write,
		.bus_wdata, .port_busy, .bus_ready, .dec(dec.decoder)
	);

	hello_rom u_rom (
		.clk, .reset_n, .dec(dec.target), .rdata(rom_rdata), .rdata_en(rom_en)
	);

	scratch_ram #(.RAM_ADDR_W(RAM_ADDR_W)) u_ram (
		.clk, .reset_n, .dec(dec.target), .rdata(ram_rdata), .rdata_en(ram_en)
	);

	console_port u_console (
		.clk, .reset_n, .dec(dec.target), .tx_ready, .tx_data, .tx_strobe,
		.busy(port_busy), .rdata(io_rdata), .rdata_en(io_en)
	);

	// Idle targets drive zero.
	assign bus_rdata    = rom_rdata | ram_rdata | io_rdata;
	assign bus_rdata_en = rom_en | ram_en | io_en;

endmodule

`default_nettype wire

/* rtl/console_port.sv */
// ----------------------------
// Console I/O target: holds a
// character, reports status.
// ----------------------------
`timescale 1ns/1ps
`default_nettype none

module console_port
	import bus_pkg::*, map_pkg::*;
(
	input  logic      clk,
	input  logic      reset_n,
	dec_if.target     dec,
	input  logic      tx_ready,
	output bus_data_t tx_data,
	output logic      tx_strobe,
	output logic      busy,
	output bus_data_t rdata,
	output logic      rdata_en
);
	console_state_t state;
	bus_data_t      hold_q;
	bus_data_t      status_q;
	logic           status_en;
	logic           put_char;

	assign put_char = dec.sel_io && dec.write && (state == cons_idle);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= cons_idle;
		end else begin
			case (state)
				cons_idle: if (put_char) state <= cons_hold;
				cons_hold: if (tx_ready) state <= cons_idle;	// Sent this cycle.
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (put_char)
			hold_q <= dec.wdata;
		if (dec.sel_io && !dec.write)
			status_q <= bus_data_t'({7'd0, (state == cons_idle) && tx_ready});
	end

	always_ff @(posedge clk) begin
		if (!reset_n)
			status_en <= 1'b0;
		else
			status_en <= dec.sel_io && !dec.write;
	end

	assign tx_strobe = (state == cons_hold) && tx_ready;
	assign tx_data   = hold_q;
	assign busy      = (state == cons_hold);
	assign rdata     = status_en ? status_q : '0;
	assign rdata_en  = status_en;

endmodule

`default_nettype wire

/* rtl/scratch_ram.sv */
// ----------------------------
// Scratch RAM target for the
// stack and program data.
// ----------------------------
`timescale 1ns/1ps
`default_nettype none

module scratch_ram
	import bus_pkg::*;
#(
	parameter int RAM_ADDR_W = 10
) (
	input  logic      clk,
	input  logic      reset_n,
	dec_if.target     dec,
	output bus_data_t rdata,
	output logic      rdata_en
);
	bus_data_t             mem [0:(1 << RAM_ADDR_W) - 1];
	logic [RAM_ADDR_W-1:0] index;
	bus_data_t             rdata_q;
	logic                  rdata_en_q;

	assign index = dec.addr[RAM_ADDR_W-1:0];	// Offset inside the RAM window.

	always_ff @(posedge clk) begin
		if (dec.sel_ram && dec.write)
			mem[index] <= dec.wdata;
		if (dec.sel_ram && !dec.write)
			rdata_q <= mem[index];
	end

	always_ff @(posedge clk) begin
		if (!reset_n)
			rdata_en_q <= 1'b0;
		else
			rdata_en_q <= dec.sel_ram && !dec.write;
	end

	assign rdata    = rdata_en_q ? rdata_q : '0;
	assign rdata_en = rdata_en_q;

endmodule

`default_nettype wire

/* rtl/hello_rom.sv */
// ----------------------------
// Boot ROM target.
// ----------------------------
`timescale 1ns/1ps
`default_nettype none

module hello_rom
	import bus_pkg::*, map_pkg::*;
(
	input  logic      clk,
	input  logic      reset_n,
	dec_if.target     dec,
	output bus_data_t rdata,
	output logic      rdata_en
);
	`include "hello_rom_image.svh"

	bus_data_t rdata_q;
	logic      rdata_en_q;

	always_ff @(posedge clk) begin
		if (!reset_n)
			rdata_en_q <= 1'b0;
		else
			rdata_en_q <= dec.sel_rom && !dec.write;	// Writes get no answer.
	end

	always_ff @(posedge clk) begin
		if (dec.sel_rom && !dec.write)
			rdata_q <= (dec.addr < ROM_SIZE) ? rom_byte(dec.addr) : '0;
	end

	assign rdata    = rdata_en_q ? rdata_q : '0;
	assign rdata_en = rdata_en_q;

endmodule

`default_nettype wire

/* rtl/bus_decoder.sv */
// ----------------------------
// Accept stage: registers bus
// requests, selects a target.
// ----------------------------
`timescale 1ns/1ps
`default_nettype none

module bus_decoder
	import bus_pkg::*, map_pkg::*;
#(
	parameter int RAM_ADDR_W = 10
) (
	input  logic      clk,
	input  logic      reset_n,
	input  bus_addr_t bus_address,
	input  logic      bus_memreq,
	input  logic      bus_valid,
	input  logic      bus_write,
	input  bus_data_t bus_wdata,
	input  logic      port_busy,
	output logic      bus_ready,
	dec_if.decoder    dec
);
	localparam bus_addr_t RAM_BASE = bus_addr_t'(RAM_END - (1 << RAM_ADDR_W));

	logic     accept;
	logic     hit_rom;
	logic     hit_ram;
	logic     hit_io;
	io_port_t port;

	assign accept  = bus_valid && bus_ready;
	assign port    = io_port_t'(bus_address[7:0]);
	assign hit_rom = bus_memreq && (bus_address[15:13] == ROM_BASE_TOP);
	assign hit_ram = bus_memreq && (bus_address >= RAM_BASE) && (bus_address < RAM_END);
	assign hit_io  = !bus_memreq && (port == CONSOLE_PORT);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			dec.sel_rom <= 1'b0;
			dec.sel_ram <= 1'b0;
			dec.sel_io  <= 1'b0;
		end else begin
			dec.sel_rom <= accept && hit_rom;
			dec.sel_ram <= accept && hit_ram && !hit_rom;	// ROM wins on overlap.
			dec.sel_io  <= accept && hit_io;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			dec.addr  <= bus_address;
			dec.write <= bus_write;
			dec.wdata <= bus_wdata;
		end
	end

	// Stall while the console holds a character or one is on its way.
	assign bus_ready = !port_busy && !(dec.sel_io && dec.write);

endmodule

`default_nettype wire

/* rtl/dec_if.sv */
// ----------------------------
// Decoded request, decoder to
// the ROM, RAM and console.
// ----------------------------
`timescale 1ns/1ps
`default_nettype none

interface dec_if
	import bus_pkg::*;
();
	logic      sel_rom;	// One-cycle selects, one-hot or none.
	logic      sel_ram;
	logic      sel_io;
	bus_addr_t addr;
	logic      write;
	bus_data_t wdata;

	modport decoder (output sel_rom, sel_ram, sel_io, addr, write, wdata);
	modport target (input sel_rom, sel_ram, sel_io, addr, write, wdata);

endinterface

`default_nettype wire

/* rtl/map_pkg.sv */
// ----------------------------
// Memory map, I/O port numbers
// and console state encoding.
// ----------------------------
`default_nettype none

package map_pkg;
	import bus_pkg::*;

	localparam logic [2:0] ROM_BASE_TOP = 3'b000;	// 0x0000-0x1FFF.
	localparam int         ROM_SIZE     = 58;
	localparam bus_addr_t  RAM_END      = 16'h4000;	// RAM sits just below.
	localparam io_port_t   CONSOLE_PORT = 8'h10;

	typedef enum logic {
		cons_idle,
		cons_hold	// Character waiting for tx_ready.
	} console_state_t;

endpackage

`default_nettype wire

/* rtl/bus_pkg.sv */
// ----------------------------
// Bus width typedefs for the
// memory and I/O subsystem.
// ----------------------------
`default_nettype none

package bus_pkg;

	typedef logic [15:0] bus_addr_t;	// Memory address.
	typedef logic [7:0]  bus_data_t;	// Data byte.
	typedef logic [7:0]  io_port_t;	// I/O port, low address byte.

endpackage

`default_nettype wire

/* include/hello_rom_image.svh */
// ----------------------------
// Boot program image, address
// to byte lookup function.
// ----------------------------
`ifndef HELLO_ROM_IMAGE_SVH
`define HELLO_ROM_IMAGE_SVH

function automatic bus_data_t rom_byte(input bus_addr_t addr);
	case (addr)
		16'd0:   rom_byte = 8'hF3;	// di
		16'd1:   rom_byte = 8'hC3;	// jp 0x0008
		16'd2:   rom_byte = 8'h08;
		16'd3:   rom_byte = 8'h00;
		16'd4:   rom_byte = 8'h00;
		16'd5:   rom_byte = 8'hC3;
		16'd6:   rom_byte = 8'h2E;
		16'd7:   rom_byte = 8'h00;
		16'd8:   rom_byte = 8'h31;	// Stack at top of RAM.
		16'd9:   rom_byte = 8'h00;
		16'd10:  rom_byte = 8'h40;
		16'd11:  rom_byte = 8'hCD;	// Poll console status.
		16'd12:  rom_byte = 8'h2B;
		16'd13:  rom_byte = 8'h00;
		16'd14:  rom_byte = 8'hE6;
		16'd15:  rom_byte = 8'h01;
		16'd16:  rom_byte = 8'h28;
		16'd17:  rom_byte = 8'hF9;
		16'd18:  rom_byte = 8'h11;
		16'd19:  rom_byte = 8'h1B;
		16'd20:  rom_byte = 8'h00;
		16'd21:  rom_byte = 8'hCD;
		16'd22:  rom_byte = 8'h2E;
		16'd23:  rom_byte = 8'h00;
		16'd24:  rom_byte = 8'hC3;
		16'd25:  rom_byte = 8'h0B;
		16'd26:  rom_byte = 8'h00;
		16'd27:  rom_byte = 8'h48;	// Message text.
		16'd28:  rom_byte = 8'h65;
		16'd29:  rom_byte = 8'h6C;
		16'd30:  rom_byte = 8'h6C;
		16'd31:  rom_byte = 8'h6F;
		16'd32:  rom_byte = 8'h2C;
		16'd33:  rom_byte = 8'h20;
		16'd34:  rom_byte = 8'h77;
		16'd35:  rom_byte = 8'h6F;
		16'd36:  rom_byte = 8'h72;
		16'd37:  rom_byte = 8'h6C;
		16'd38:  rom_byte = 8'h64;
		16'd39:  rom_byte = 8'h21;
		16'd40:  rom_byte = 8'h0D;
		16'd41:  rom_byte = 8'h0A;
		16'd42:  rom_byte = 8'h00;
		16'd43:  rom_byte = 8'hDB;	// in a,(0x10)
		16'd44:  rom_byte = 8'h10;
		16'd45:  rom_byte = 8'hC9;
		16'd46:  rom_byte = 8'hF5;	// Print loop.
		16'd47:  rom_byte = 8'h1A;
		16'd48:  rom_byte = 8'h13;
		16'd49:  rom_byte = 8'hB7;
		16'd50:  rom_byte = 8'h28;
		16'd51:  rom_byte = 8'h04;
		16'd52:  rom_byte = 8'hD3;
		16'd53:  rom_byte = 8'h10;
		16'd54:  rom_byte = 8'h18;
		16'd55:  rom_byte = 8'hF7;
		16'd56:  rom_byte = 8'hF1;
		16'd57:  rom_byte = 8'hC9;
		default: rom_byte = 8'h00;
	endcase
endfunction

`endif
